/* common/cong_man_config.svh */
////////////////////
// Congestion manager sizing
////////////////////
`ifndef CONG_MAN_CONFIG_SVH
`define CONG_MAN_CONFIG_SVH

// Egress side
`define CM_NUM_EGR_PORTS 4
`define CM_QUEUES_PER_PORT 2
`define CM_NUM_QUEUES (`CM_NUM_EGR_PORTS * `CM_QUEUES_PER_PORT)

// Queue memory geometry
`define CM_DATA_BYTES 64
`define CM_BYTES_PER_PAGE 4096
`define CM_WORDS_PER_PAGE (`CM_BYTES_PER_PAGE / `CM_DATA_BYTES)
`define CM_NUM_PAGES 8

// Largest packet accepted
`define CM_MTU_BYTES 1500

// Priority classes
`define CM_HIGH_PRIO_MIN 5
`define CM_POLICER_EXEMPT_PRIO 6

// Whole buffer, so nothing drops on depth until configured
`define CM_DEFAULT_THRESHOLD (`CM_NUM_PAGES * `CM_BYTES_PER_PAGE)

`endif

/* common/descriptor_pkg.sv */
////////////////////
// Packet descriptor types
////////////////////
`include "cong_man_config.svh"

package descriptor_pkg;

    // Round-up word count of one MTU packet
    localparam int MAX_WORD_LEN = (`CM_MTU_BYTES + `CM_DATA_BYTES - 1) / `CM_DATA_BYTES;

    // Egress port number
    typedef logic [$clog2(`CM_NUM_EGR_PORTS)-1:0] port_t;

    // Eight priority levels
    typedef logic [2:0] prio_t;

    // Length in bytes, up to one MTU
    typedef logic [$clog2(`CM_MTU_BYTES + 1)-1:0] byte_len_t;

    // Length in memory words
    typedef logic [$clog2(MAX_WORD_LEN + 1)-1:0] word_len_t;

    // Flat queue number across all ports
    typedef logic [$clog2(`CM_NUM_QUEUES)-1:0] queue_idx_t;

endpackage

/* common/queue_state_pkg.sv */
////////////////////
// Queue state and verdict types
////////////////////
`include "cong_man_config.svh"

package queue_state_pkg;

    // Bytes currently held by one queue
    typedef logic [31:0] occupancy_t;

    // Word offset of the tail inside its page
    typedef logic [$clog2(`CM_WORDS_PER_PAGE)-1:0] word_ptr_t;

    // Page number in queue memory
    typedef logic [$clog2(`CM_NUM_PAGES)-1:0] page_idx_t;

    // Extra bit so the full pool count fits
    typedef logic [$clog2(`CM_NUM_PAGES + 1)-1:0] page_count_t;

    ////////////////////
    // Admission outcome

    typedef enum logic [1:0] {
        ENQUEUE,
        DROP_QUEUE_FULL,
        DROP_POLICER,
        DROP_NO_PAGE
    } verdict_e;

endpackage

/* src/queue_state_table.sv */
////////////////////
// Per-queue state
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module queue_state_table (
    input  logic                        core_clk_ifc,
    input  logic                        rst_n,
    input  descriptor_pkg::queue_idx_t  rd_queue,
    input  logic                        upd_en,
    input  descriptor_pkg::queue_idx_t  upd_queue,
    input  queue_state_pkg::occupancy_t upd_occupancy,
    input  queue_state_pkg::word_ptr_t  upd_tail,
    input  queue_state_pkg::page_idx_t  upd_page,
    output queue_state_pkg::occupancy_t rd_occupancy,
    output queue_state_pkg::word_ptr_t  rd_tail,
    output queue_state_pkg::page_idx_t  rd_page,
    output logic                        rd_page_valid
);
    import queue_state_pkg::*;

    occupancy_t                occupancy [`CM_NUM_QUEUES];
    word_ptr_t                 tail      [`CM_NUM_QUEUES];
    page_idx_t                 page      [`CM_NUM_QUEUES];
    logic [`CM_NUM_QUEUES-1:0] page_valid;

    // Empty queues start at offset 0 with no page held
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < `CM_NUM_QUEUES; q++) begin
                occupancy[q] <= '0;
                tail[q]      <= '0;
                page[q]      <= '0;
            end
            page_valid <= '0;
        end else if (upd_en) begin
            occupancy[upd_queue]  <= upd_occupancy;
            tail[upd_queue]       <= upd_tail;
            page[upd_queue]       <= upd_page;
            // Every enqueue leaves the queue holding a page
            page_valid[upd_queue] <= 1'b1;
        end
    end

    ////////////////////
    // Read port

    assign rd_occupancy  = occupancy[rd_queue];
    assign rd_tail       = tail[rd_queue];
    assign rd_page       = page[rd_queue];
    assign rd_page_valid = page_valid[rd_queue];

endmodule

/* src/drop_threshold_table.sv */
////////////////////
// Drop thresholds
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module drop_threshold_table (
    input  logic                        core_clk_ifc,
    input  logic                        rst_n,
    input  logic                        cfg_wr,
    input  descriptor_pkg::queue_idx_t  cfg_queue,
    input  queue_state_pkg::occupancy_t cfg_threshold,
    input  descriptor_pkg::queue_idx_t  rd_queue,
    output queue_state_pkg::occupancy_t rd_threshold
);
    import queue_state_pkg::*;

    // Byte limit per queue
    occupancy_t threshold [`CM_NUM_QUEUES];

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < `CM_NUM_QUEUES; q++) begin
                threshold[q] <= occupancy_t'(`CM_DEFAULT_THRESHOLD);
            end
        end else if (cfg_wr) begin
            threshold[cfg_queue] <= cfg_threshold;
        end
    end

    // Visible to the decider on the cycle after the write
    assign rd_threshold = threshold[rd_queue];

endmodule

/* src/page_allocator.sv */
////////////////////
// Page allocator
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module page_allocator (
    input  logic                         core_clk_ifc,
    input  logic                         rst_n,
    input  logic                         alloc_en,
    output queue_state_pkg::page_count_t free_pages,
    output queue_state_pkg::page_idx_t   next_page
);
    import queue_state_pkg::*;

    // Pages are never returned, so the pool is handed out in index order
    // and the next free page is simply a counter
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            free_pages <= page_count_t'(`CM_NUM_PAGES);
            next_page  <= '0;
        end else if (alloc_en) begin
            // Decider only requests while free_pages is nonzero
            free_pages <= free_pages - 1'b1;
            next_page  <= next_page + 1'b1;
        end
    end

endmodule

/* cong_man/queue_classifier.sv */
////////////////////
// Descriptor classifier
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module queue_classifier (
    input  logic                       core_clk_ifc,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  descriptor_pkg::port_t      in_port,
    input  descriptor_pkg::prio_t      in_prio,
    input  descriptor_pkg::byte_len_t  in_byte_len,
    input  logic                       in_policer_mark,
    output logic                       cls_valid,
    output descriptor_pkg::queue_idx_t cls_queue,
    output descriptor_pkg::byte_len_t  cls_byte_len,
    output descriptor_pkg::word_len_t  cls_word_len,
    output descriptor_pkg::prio_t      cls_prio,
    output logic                       cls_policer_mark
);
    import descriptor_pkg::*;

    queue_idx_t queue_d;
    word_len_t  word_len_d;

    // Each port owns a block of queues, high priorities take the second one
    always_comb begin
        queue_d = queue_idx_t'(in_port * `CM_QUEUES_PER_PORT);
        if (in_prio >= `CM_HIGH_PRIO_MIN) begin
            queue_d = queue_d + 1'b1;
        end
    end

    // Words rounded up, a partial last word still takes a whole one
    assign word_len_d = word_len_t'((in_byte_len + `CM_DATA_BYTES - 1) / `CM_DATA_BYTES);

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            cls_valid <= 1'b0;
        end else begin
            cls_valid <= in_valid;
        end
    end

    // Descriptor fields
    always_ff @(posedge core_clk_ifc) begin
        if (in_valid) begin
            cls_queue        <= queue_d;
            cls_byte_len     <= in_byte_len;
            cls_word_len     <= word_len_d;
            cls_prio         <= in_prio;
            cls_policer_mark <= in_policer_mark;
        end
    end

endmodule

/* cong_man/admission_decider.sv */
////////////////////
// Admission decision
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module admission_decider (
    input  logic                         core_clk_ifc,
    input  logic                         rst_n,
    input  logic                         cls_valid,
    input  descriptor_pkg::queue_idx_t   cls_queue,
    input  descriptor_pkg::byte_len_t    cls_byte_len,
    input  descriptor_pkg::word_len_t    cls_word_len,
    input  descriptor_pkg::prio_t        cls_prio,
    input  logic                         cls_policer_mark,
    input  queue_state_pkg::occupancy_t  rd_threshold,
    input  queue_state_pkg::occupancy_t  rd_occupancy,
    input  queue_state_pkg::word_ptr_t   rd_tail,
    input  queue_state_pkg::page_idx_t   rd_page,
    input  logic                         rd_page_valid,
    input  queue_state_pkg::page_count_t free_pages,
    input  queue_state_pkg::page_idx_t   next_page,
    output logic                         upd_en,
    output descriptor_pkg::queue_idx_t   upd_queue,
    output queue_state_pkg::occupancy_t  upd_occupancy,
    output queue_state_pkg::word_ptr_t   upd_tail,
    output queue_state_pkg::page_idx_t   upd_page,
    output logic                         alloc_en,
    output logic                         verdict_valid,
    output queue_state_pkg::verdict_e    verdict,
    output descriptor_pkg::queue_idx_t   verdict_queue,
    output logic                         verdict_malloc,
    output queue_state_pkg::word_ptr_t   verdict_tail,
    output queue_state_pkg::page_idx_t   verdict_page
);
    import queue_state_pkg::*;

    occupancy_t                 new_occupancy;
    occupancy_t                 occ_pages;
    logic [$bits(word_ptr_t):0] tail_sum;
    logic                       malloc_req;
    logic                       enqueue;
    verdict_e                   verdict_d;

    assign new_occupancy = rd_occupancy + occupancy_t'(cls_byte_len);
    assign occ_pages     = rd_occupancy / `CM_BYTES_PER_PAGE;

    // Carry out of the page offset means the packet spills into a new page
    assign tail_sum   = rd_tail + cls_word_len;
    assign malloc_req = !rd_page_valid || (tail_sum >= `CM_WORDS_PER_PAGE);

    ////////////////////
    // Drop rules, first match wins

    always_comb begin
        if (new_occupancy > rd_threshold) begin
            verdict_d = DROP_QUEUE_FULL;
        end else if (cls_policer_mark && (cls_prio < `CM_POLICER_EXEMPT_PRIO)) begin
            verdict_d = DROP_POLICER;
        end else if (malloc_req && (occ_pages > free_pages)) begin
            // Deep queues give way so the last pages go to short ones
            verdict_d = DROP_NO_PAGE;
        end else if (malloc_req && (free_pages == '0)) begin
            verdict_d = DROP_NO_PAGE;
        end else begin
            verdict_d = ENQUEUE;
        end
    end

    // Write-back lands on the same edge as the verdict register
    assign enqueue       = cls_valid && (verdict_d == ENQUEUE);
    assign upd_en        = enqueue;
    assign upd_queue     = cls_queue;
    assign upd_occupancy = new_occupancy;
    assign upd_tail      = word_ptr_t'(tail_sum % `CM_WORDS_PER_PAGE);
    assign upd_page      = malloc_req ? next_page : rd_page;
    assign alloc_en      = enqueue && malloc_req;

    ////////////////////
    // Verdict register

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            verdict_valid <= 1'b0;
        end else begin
            verdict_valid <= cls_valid;
        end
    end

    // Drops report the queue state they were judged against
    always_ff @(posedge core_clk_ifc) begin
        if (cls_valid) begin
            verdict        <= verdict_d;
            verdict_queue  <= cls_queue;
            verdict_malloc <= alloc_en;
            verdict_tail   <= enqueue ? upd_tail : rd_tail;
            verdict_page   <= enqueue ? upd_page : rd_page;
        end
    end

endmodule

/* cong_man/cong_man_top.sv */
////////////////////
// Congestion manager top
////////////////////
`timescale 1ns/1ps

module cong_man_top (
    input  logic                         core_clk_ifc,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  descriptor_pkg::port_t        in_port,
    input  descriptor_pkg::prio_t        in_prio,
    input  descriptor_pkg::byte_len_t    in_byte_len,
    input  logic                         in_policer_mark,
    input  logic                         cfg_wr,
    input  descriptor_pkg::queue_idx_t   cfg_queue,
    input  queue_state_pkg::occupancy_t  cfg_threshold,
    output logic                         verdict_valid,
    output queue_state_pkg::verdict_e    verdict,
    output descriptor_pkg::queue_idx_t   verdict_queue,
    output logic                         verdict_malloc,
    output queue_state_pkg::word_ptr_t   verdict_tail,
    output queue_state_pkg::page_idx_t   verdict_page,
    output queue_state_pkg::page_count_t free_pages
);
    import descriptor_pkg::*;
    import queue_state_pkg::*;

    ////////////////////
    // Classifier to decider
    logic       cls_valid;
    queue_idx_t cls_queue;
    byte_len_t  cls_byte_len;
    word_len_t  cls_word_len;
    prio_t      cls_prio;
    logic       cls_policer_mark;

    // Table read data for cls_queue
    occupancy_t rd_threshold;
    occupancy_t rd_occupancy;
    word_ptr_t  rd_tail;
    page_idx_t  rd_page;
    logic       rd_page_valid;

    // Enqueue write-back and page request
    logic       upd_en;
    queue_idx_t upd_queue;
    occupancy_t upd_occupancy;
    word_ptr_t  upd_tail;
    page_idx_t  upd_page;
    logic       alloc_en;
    page_idx_t  next_page;

    queue_classifier u_classifier (
        .core_clk_ifc     (core_clk_ifc),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_port          (in_port),
        .in_prio          (in_prio),
        .in_byte_len      (in_byte_len),
        .in_policer_mark  (in_policer_mark),
        .cls_valid        (cls_valid),
        .cls_queue        (cls_queue),
        .cls_byte_len     (cls_byte_len),
        .cls_word_len     (cls_word_len),
        .cls_prio         (cls_prio),
        .cls_policer_mark (cls_policer_mark)
    );

    drop_threshold_table u_thresholds (
        .core_clk_ifc  (core_clk_ifc),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .cfg_queue     (cfg_queue),
        .cfg_threshold (cfg_threshold),
        .rd_queue      (cls_queue),
        .rd_threshold  (rd_threshold)
    );

    queue_state_table u_queue_state (
        .core_clk_ifc  (core_clk_ifc),
        .rst_n         (rst_n),
        .rd_queue      (cls_queue),
        .upd_en        (upd_en),
        .upd_queue     (upd_queue),
        .upd_occupancy (upd_occupancy),
        .upd_tail      (upd_tail),
        .upd_page      (upd_page),
        .rd_occupancy  (rd_occupancy),
        .rd_tail       (rd_tail),
        .rd_page       (rd_page),
        .rd_page_valid (rd_page_valid)
    );

    page_allocator u_pages (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .alloc_en     (alloc_en),
        .free_pages   (free_pages),
        .next_page    (next_page)
    );

    admission_decider u_decider (
        .core_clk_ifc     (core_clk_ifc),
        .rst_n            (rst_n),
        .cls_valid        (cls_valid),
        .cls_queue        (cls_queue),
        .cls_byte_len     (cls_byte_len),
        .cls_word_len     (cls_word_len),
        .cls_prio         (cls_prio),
        .cls_policer_mark (cls_policer_mark),
        .rd_threshold     (rd_threshold),
        .rd_occupancy     (rd_occupancy),
        .rd_tail          (rd_tail),
        .rd_page          (rd_page),
        .rd_page_valid    (rd_page_valid),
        .free_pages       (free_pages),
        .next_page        (next_page),
        .upd_en           (upd_en),
        .upd_queue        (upd_queue),
        .upd_occupancy    (upd_occupancy),
        .upd_tail         (upd_tail),
        .upd_page         (upd_page),
        .alloc_en         (alloc_en),
        .verdict_valid    (verdict_valid),
        .verdict          (verdict),
        .verdict_queue    (verdict_queue),
        .verdict_malloc   (verdict_malloc),
        .verdict_tail     (verdict_tail),
        .verdict_page     (verdict_page)
    );

endmodule

/* verification/cong_man_checker.sv */
////////////////////
// Congestion manager assertions
////////////////////
`timescale 1ns/1ps

module cong_man_checker (
    input logic                         core_clk_ifc,
    input logic                         rst_n,
    input logic                         in_valid,
    input logic                         cls_valid,
    input logic                         upd_en,
    input logic                         alloc_en,
    input logic                         verdict_valid,
    input queue_state_pkg::verdict_e    verdict,
    input logic                         verdict_malloc,
    input queue_state_pkg::page_count_t free_pages
);
    import queue_state_pkg::*;

    int   assert_failures = 0;
    logic page_taken;

    assign page_taken = verdict_valid && (verdict == ENQUEUE) && verdict_malloc;

    // Classifier stage plus verdict register
    a_latency: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        verdict_valid == $past(in_valid, 2)) else begin
        $error("verdict_valid not two cycles after in_valid");
        assert_failures++;
    end

    // Pages are never returned
    a_no_rise: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        free_pages <= $past(free_pages)) else begin
        $error("free_pages rose");
        assert_failures++;
    end

    a_page_taken: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        page_taken |-> free_pages == $past(free_pages) - 1) else begin
        $error("free_pages did not fall with a malloc verdict");
        assert_failures++;
    end

    a_page_held: assert property (@(posedge core_clk_ifc) disable iff (!rst_n)
        !page_taken |-> free_pages == $past(free_pages)) else begin
        $error("free_pages changed without a malloc verdict");
        assert_failures++;
    end

    a_reset_quiet: assert property (@(posedge core_clk_ifc)
        !rst_n |-> !(verdict_valid || upd_en || alloc_en || cls_valid)) else begin
        $error("control output high during reset");
        assert_failures++;
    end

endmodule

bind cong_man_top cong_man_checker u_checker (
    .core_clk_ifc   (core_clk_ifc),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .cls_valid      (cls_valid),
    .upd_en         (upd_en),
    .alloc_en       (alloc_en),
    .verdict_valid  (verdict_valid),
    .verdict        (verdict),
    .verdict_malloc (verdict_malloc),
    .free_pages     (free_pages)
);

/* verification/cong_man_tb.sv */
////////////////////
// Congestion manager testbench
////////////////////
`timescale 1ns/1ps
`include "cong_man_config.svh"

module cong_man_tb;
    import descriptor_pkg::*;
    import queue_state_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_QUEUES     = `CM_NUM_EGR_PORTS * `CM_QUEUES_PER_PORT;
    // Table length of zero asks for a random length of one word or less
    localparam int RANDOM_LEN     = 0;

    typedef struct {
        bit         is_cfg;
        port_t      port;
        prio_t      prio;
        int         len;
        bit         mark;
        queue_idx_t cfg_queue;
        occupancy_t cfg_threshold;
        verdict_e   exp_verdict;
        queue_idx_t exp_queue;
    } entry_t;

    typedef struct {
        verdict_e    verdict;
        queue_idx_t  queue;
        logic        malloc;
        word_ptr_t   tail;
        page_idx_t   page;
        page_count_t free;
    } result_t;

    logic        core_clk_ifc;
    logic        rst_n;
    logic        in_valid;
    port_t       in_port;
    prio_t       in_prio;
    byte_len_t   in_byte_len;
    logic        in_policer_mark;
    logic        cfg_wr;
    queue_idx_t  cfg_queue;
    occupancy_t  cfg_threshold;
    logic        verdict_valid;
    verdict_e    verdict;
    queue_idx_t  verdict_queue;
    logic        verdict_malloc;
    word_ptr_t   verdict_tail;
    page_idx_t   verdict_page;
    page_count_t free_pages;

    entry_t  table_q[$];
    result_t expect_q[$];
    int      error_count;
    int      check_count;

    // Reference queue state
    int m_occ   [NUM_QUEUES];
    int m_tail  [NUM_QUEUES];
    int m_page  [NUM_QUEUES];
    bit m_valid [NUM_QUEUES];
    int m_thr   [NUM_QUEUES];
    int m_free;
    int m_next;

    cong_man_top dut (
        .core_clk_ifc    (core_clk_ifc),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_port         (in_port),
        .in_prio         (in_prio),
        .in_byte_len     (in_byte_len),
        .in_policer_mark (in_policer_mark),
        .cfg_wr          (cfg_wr),
        .cfg_queue       (cfg_queue),
        .cfg_threshold   (cfg_threshold),
        .verdict_valid   (verdict_valid),
        .verdict         (verdict),
        .verdict_queue   (verdict_queue),
        .verdict_malloc  (verdict_malloc),
        .verdict_tail    (verdict_tail),
        .verdict_page    (verdict_page),
        .free_pages      (free_pages)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////
    // Stimulus table

    function automatic void add_desc(input int port, input int prio, input int len,
                                     input bit mark, input verdict_e v, input int q);
        entry_t e;
        e.is_cfg        = 1'b0;
        e.port          = port_t'(port);
        e.prio          = prio_t'(prio);
        e.len           = len;
        e.mark          = mark;
        e.cfg_queue     = '0;
        e.cfg_threshold = '0;
        e.exp_verdict   = v;
        e.exp_queue     = queue_idx_t'(q);
        table_q.push_back(e);
    endfunction

    function automatic void add_cfg(input int q, input int threshold);
        entry_t e;
        e.is_cfg        = 1'b1;
        e.port          = '0;
        e.prio          = '0;
        e.len           = 0;
        e.mark          = 1'b0;
        e.cfg_queue     = queue_idx_t'(q);
        e.cfg_threshold = occupancy_t'(threshold);
        e.exp_verdict   = ENQUEUE;
        e.exp_queue     = '0;
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        // Empty queue, then a back-to-back small packet
        add_desc(0, 0, 200, 0, ENQUEUE, 0);
        add_desc(0, 0, 100, 0, ENQUEUE, 0);
        // Thresholds, exact fit then one byte over
        add_cfg(0, 1000);
        add_cfg(1, 500);
        add_desc(0, 0, 700, 0, ENQUEUE, 0);
        add_desc(0, 0, 1, 0, DROP_QUEUE_FULL, 0);
        add_desc(0, 5, 500, 0, ENQUEUE, 1);
        add_desc(0, 5, 1, 0, DROP_QUEUE_FULL, 1);
        // Policer mark against every priority
        for (int p = 0; p < 8; p++) begin
            add_desc(1, p, RANDOM_LEN, 1, (p < 6) ? DROP_POLICER : ENQUEUE, (p < 5) ? 2 : 3);
        end
        // MTU packets walking one queue across page ends
        for (int n = 0; n < 7; n++) begin
            add_desc(2, 0, 1500, 0, ENQUEUE, 4);
        end
        // Last two pages, deep queue gives way, then pool empty
        add_desc(3, 0, 64, 0, ENQUEUE, 6);
        add_desc(2, 0, 1500, 0, DROP_NO_PAGE, 4);
        add_desc(3, 5, 64, 0, ENQUEUE, 7);
        add_desc(2, 5, 100, 0, DROP_NO_PAGE, 5);
        add_desc(3, 0, 128, 0, ENQUEUE, 6);
        // Priority split on one port
        for (int p = 0; p < 8; p++) begin
            add_desc(3, p, RANDOM_LEN, 0, ENQUEUE, (p < 5) ? 6 : 7);
        end
    endfunction

    ////////////////////
    // Reference model

    function automatic void reset_model();
        for (int q = 0; q < NUM_QUEUES; q++) begin
            m_occ[q]   = 0;
            m_tail[q]  = 0;
            m_page[q]  = 0;
            m_valid[q] = 1'b0;
            m_thr[q]   = `CM_DEFAULT_THRESHOLD;
        end
        m_free = `CM_NUM_PAGES;
        m_next = 0;
    endfunction

    function automatic result_t predict(input entry_t e, input int len);
        result_t r;
        int      q;
        int      words;
        bit      need_page;
        q         = e.port * `CM_QUEUES_PER_PORT + ((e.prio >= `CM_HIGH_PRIO_MIN) ? 1 : 0);
        words     = (len + `CM_DATA_BYTES - 1) / `CM_DATA_BYTES;
        need_page = !m_valid[q] || (m_tail[q] + words >= `CM_WORDS_PER_PAGE);
        if (m_occ[q] + len > m_thr[q]) begin
            r.verdict = DROP_QUEUE_FULL;
        end else if (e.mark && e.prio < `CM_POLICER_EXEMPT_PRIO) begin
            r.verdict = DROP_POLICER;
        end else if (need_page && (m_occ[q] / `CM_BYTES_PER_PAGE > m_free || m_free == 0)) begin
            r.verdict = DROP_NO_PAGE;
        end else begin
            r.verdict = ENQUEUE;
        end
        r.malloc = (r.verdict == ENQUEUE) && need_page;
        if (r.verdict == ENQUEUE) begin
            if (need_page) begin
                m_page[q] = m_next;
                m_next++;
                m_free--;
            end
            m_tail[q]  = (m_tail[q] + words) % `CM_WORDS_PER_PAGE;
            m_occ[q]   = m_occ[q] + len;
            m_valid[q] = 1'b1;
        end
        r.queue = queue_idx_t'(q);
        r.tail  = word_ptr_t'(m_tail[q]);
        r.page  = page_idx_t'(m_page[q]);
        r.free  = page_count_t'(m_free);
        return r;
    endfunction

    ////////////////////
    // Drive and collect

    task automatic apply_entry(input entry_t e, input int idx);
        result_t r;
        int      len;
        @(posedge core_clk_ifc);
        #1;
        in_valid = 1'b0;
        cfg_wr   = 1'b0;
        if (e.is_cfg) begin
            cfg_wr           = 1'b1;
            cfg_queue        = e.cfg_queue;
            cfg_threshold    = e.cfg_threshold;
            m_thr[e.cfg_queue] = e.cfg_threshold;
        end else begin
            len = (e.len == RANDOM_LEN) ? 1 + ($urandom % `CM_DATA_BYTES) : e.len;
            r   = predict(e, len);
            if (r.verdict != e.exp_verdict) begin
                $display("Entry %0d: drop rules give %s but the table expects %s",
                         idx, r.verdict.name(), e.exp_verdict.name());
                error_count++;
            end
            r.verdict       = e.exp_verdict;
            r.queue         = e.exp_queue;
            in_valid        = 1'b1;
            in_port         = e.port;
            in_prio         = e.prio;
            in_byte_len     = byte_len_t'(len);
            in_policer_mark = e.mark;
            expect_q.push_back(r);
        end
    endtask

    task automatic wait_verdict(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge core_clk_ifc);
            if (verdict_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic compare_verdict(input verdict_e got, input verdict_e exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR verdict: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic compare_queue(input queue_idx_t got, input queue_idx_t exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR verdict_queue: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR verdict_malloc: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic compare_tail(input word_ptr_t got, input word_ptr_t exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR verdict_tail: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic compare_page(input page_idx_t got, input page_idx_t exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR verdict_page: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic compare_count(input page_count_t got, input page_count_t exp, input int idx);
        check_count++;
        if (got !== exp) begin
            $display("ERROR free_pages: got %h expected %h (descriptor %0d)", got, exp, idx);
            error_count++;
        end
    endtask

    task automatic collect_verdicts(input int count);
        result_t r;
        bit      seen;
        for (int i = 0; i < count; i++) begin
            wait_verdict(seen);
            if (!seen) begin
                $display("Timed out waiting for verdict_valid on descriptor %0d", i);
                error_count++;
                break;
            end
            if (expect_q.size() == 0) begin
                $display("verdict_valid rose with no descriptor outstanding");
                error_count++;
                break;
            end
            r = expect_q.pop_front();
            compare_verdict(verdict, r.verdict, i);
            compare_queue(verdict_queue, r.queue, i);
            compare_flag(verdict_malloc, r.malloc, i);
            compare_tail(verdict_tail, r.tail, i);
            compare_page(verdict_page, r.page, i);
            compare_count(free_pages, r.free, i);
        end
    endtask

    ////////////////////
    // Main sequence

    initial begin
        int n_desc;
        int assert_errors;
        void'($urandom(32'h70af_e98d));
        rst_n           = 1'b1;
        in_valid        = 1'b0;
        in_port         = '0;
        in_prio         = '0;
        in_byte_len     = '0;
        in_policer_mark = 1'b0;
        cfg_wr          = 1'b0;
        cfg_queue       = '0;
        cfg_threshold   = '0;
        error_count     = 0;
        check_count     = 0;
        reset_model();
        build_table();
        n_desc = 0;
        foreach (table_q[i]) begin
            if (!table_q[i].is_cfg) begin
                n_desc++;
            end
        end

        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge core_clk_ifc);
        #1;
        rst_n = 1'b1;

        fork
            begin
                foreach (table_q[i]) begin
                    apply_entry(table_q[i], i);
                end
                @(posedge core_clk_ifc);
                #1;
                in_valid = 1'b0;
                cfg_wr   = 1'b0;
            end
            collect_verdicts(n_desc);
        join

        assert_errors = dut.u_checker.assert_failures;
        $display("Checks %0d, compare errors %0d, assertion failures %0d",
                 check_count, error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/descriptor_pkg.sv
common/queue_state_pkg.sv
src/queue_state_table.sv
src/drop_threshold_table.sv
src/page_allocator.sv
cong_man/queue_classifier.sv
cong_man/admission_decider.sv
cong_man/cong_man_top.sv
verification/cong_man_checker.sv
verification/cong_man_tb.sv

/* Bender.yml */
package:
  name: cong_man

sources:
  - include_dirs:
      - common
    files:
      - common/descriptor_pkg.sv
      - common/queue_state_pkg.sv
      - src/queue_state_table.sv
      - src/drop_threshold_table.sv
      - src/page_allocator.sv
      - cong_man/queue_classifier.sv
      - cong_man/admission_decider.sv
      - cong_man/cong_man_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/cong_man_checker.sv
      - verification/cong_man_tb.sv
